/* logic/lz_sym_pkg.sv */
`default_nettype none

package lz_sym_pkg;

   typedef logic [7:0]  lane_byte_t;
   typedef logic [1:0]  lane_idx_t;
   typedef logic [3:0]  framing_t;
   typedef logic [31:0] beat_data_t;
   typedef logic [7:0]  ptr_length_t;
   typedef logic [7:0]  offset_msb_t;
   typedef logic [15:0] ptr_offset_t;
   typedef logic [2:0]  lit_cnt_t;
   typedef logic [31:0] sym_data_t;
   typedef logic [54:0] beat_word_t;
   typedef logic [38:0] sym_word_t;

   localparam framing_t FRM_NONE = 4'd0;
   localparam framing_t FRM_LIT1 = 4'd1;
   localparam framing_t FRM_LIT2 = 4'd2;
   localparam framing_t FRM_LIT3 = 4'd3;
   localparam framing_t FRM_LIT4 = 4'd4;
   localparam framing_t FRM_EOB  = 4'd8;
   localparam framing_t FRM_EOF  = 4'd15;

   // Queued beat layout
   localparam int BW_LANE_LSB = 0;
   localparam int BW_BACKREF  = 2;
   localparam int BW_LEN_LSB  = 3;
   localparam int BW_OMSB_LSB = 11;
   localparam int BW_DATA_LSB = 19;
   localparam int BW_FRM_LSB  = 51;

   // Lane FIFO word layout
   localparam int SW_DATA_LSB = 0;
   localparam int SW_CNT_LSB  = 32;
   localparam int SW_EOB      = 35;
   localparam int SW_EOF      = 36;
   localparam int SW_PTR      = 37;
   localparam int SW_LIT      = 38;

   localparam int BEAT_FIFO_DEPTH  = 32;
   localparam int LANE_FIFO_DEPTH  = 16;
   localparam int BEAT_READY_LIMIT = 28;  // Leaves room for the capture pipeline
   localparam int LANE_SPACE_MIN   = 1;
   localparam int NUM_LANES        = 4;

endpackage

`default_nettype wire

/* logic/lz_sym_wr_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface lz_sym_wr_if;

   logic                   wr      [lz_sym_pkg::NUM_LANES];  // Per-lane write strobes
   lz_sym_pkg::sym_word_t  wr_word [lz_sym_pkg::NUM_LANES];
   logic                   space;                            // Every lane can take a beat

   modport packer (
      output wr,
      output wr_word
   );

   modport lanes (
      input  wr,
      input  wr_word,
      output space
   );

endinterface

`default_nettype wire

/* logic/lz_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

// DEPTH must be a power of two so the pointers wrap on their own
module lz_fifo #(
   parameter int DEPTH = 16,
   parameter int WIDTH = 32
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        wen_i,
   input  logic [WIDTH-1:0]            wdata_i,
   input  logic                        ren_i,
   output logic [WIDTH-1:0]            rdata_o,
   output logic                        empty_o,
   output logic [$clog2(DEPTH+1)-1:0]  used_o,
   output logic [$clog2(DEPTH+1)-1:0]  free_o
);

   logic [WIDTH-1:0]              mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]      wr_ptr;
   logic [$clog2(DEPTH)-1:0]      rd_ptr;
   logic [$clog2(DEPTH+1)-1:0]    used;
   logic                          do_wr;
   logic                          do_rd;

   assign do_wr = wen_i && (used != DEPTH[$clog2(DEPTH+1)-1:0]);  // Drop when full
   assign do_rd = ren_i && !empty_o;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         used   <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         used <= used + do_wr - do_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wdata_i;
      end
   end

   assign rdata_o = mem[rd_ptr];  // Head entry
   assign empty_o = (used == '0);
   assign used_o  = used;
   assign free_o  = DEPTH[$clog2(DEPTH+1)-1:0] - used;

endmodule

`default_nettype wire

/* logic/lz_beat_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module lz_beat_queue (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     valid_i,
   input  lz_sym_pkg::framing_t     framing_i,
   input  lz_sym_pkg::beat_data_t   data_i,
   input  lz_sym_pkg::offset_msb_t  offset_msb_i,
   input  lz_sym_pkg::ptr_length_t  length_i,
   input  logic                     backref_i,
   input  lz_sym_pkg::lane_idx_t    backref_lane_i,
   input  logic                     bypass_i,
   input  logic                     pop_i,
   output lz_sym_pkg::beat_word_t   beat_o,
   output logic                     beat_avail_o,
   output logic                     ready_o
);

   logic                                             cap_vld;
   lz_sym_pkg::beat_word_t                           cap_word;
   logic                                             fifo_empty;
   logic [$clog2(lz_sym_pkg::BEAT_FIFO_DEPTH+1)-1:0] fifo_used;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cap_vld <= 1'b0;
      end else begin
         cap_vld <= valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (valid_i) begin
         cap_word[lz_sym_pkg::BW_FRM_LSB  +: 4]  <= framing_i;
         cap_word[lz_sym_pkg::BW_DATA_LSB +: 32] <= data_i;
         cap_word[lz_sym_pkg::BW_OMSB_LSB +: 8]  <= offset_msb_i;
         cap_word[lz_sym_pkg::BW_LEN_LSB  +: 8]  <= length_i;
         // Bypass turns every beat into plain literals
         cap_word[lz_sym_pkg::BW_BACKREF]        <= backref_i && !bypass_i;
         cap_word[lz_sym_pkg::BW_LANE_LSB +: 2]  <= bypass_i ? 2'b00 : backref_lane_i;
      end
   end

   lz_fifo #(
      .DEPTH (lz_sym_pkg::BEAT_FIFO_DEPTH),
      .WIDTH ($bits(lz_sym_pkg::beat_word_t))
   ) u_beat_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .wen_i   (cap_vld),
      .wdata_i (cap_word),
      .ren_i   (pop_i),
      .rdata_o (beat_o),
      .empty_o (fifo_empty),
      .used_o  (fifo_used),
      .free_o  ()
   );

   assign beat_avail_o = !fifo_empty;
   assign ready_o      = (fifo_used <= lz_sym_pkg::BEAT_READY_LIMIT);

endmodule

`default_nettype wire

/* logic/lz_beat_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module lz_beat_decode (
   input  logic                     clk,
   input  logic                     rst_n,
   input  lz_sym_pkg::beat_word_t   beat_i,
   input  logic                     beat_avail_i,
   input  logic                     space_i,
   output logic                     pop_o,
   output logic                     lit_valid_o  [lz_sym_pkg::NUM_LANES],
   output lz_sym_pkg::lane_byte_t   lit_byte_o   [lz_sym_pkg::NUM_LANES],
   output logic                     ptr_valid_o  [lz_sym_pkg::NUM_LANES],
   output lz_sym_pkg::ptr_offset_t  ptr_offset_o [lz_sym_pkg::NUM_LANES],
   output lz_sym_pkg::ptr_length_t  ptr_length_o [lz_sym_pkg::NUM_LANES],
   output logic                     eof_o,
   output logic                     eob_o,
   output lz_sym_pkg::beat_data_t   eof_code_o
);

   lz_sym_pkg::framing_t     frm;
   lz_sym_pkg::beat_data_t   data;
   lz_sym_pkg::offset_msb_t  offset_msb;
   lz_sym_pkg::ptr_length_t  length;
   logic                     backref;
   lz_sym_pkg::lane_idx_t    backref_lane;
   lz_sym_pkg::lit_cnt_t     lit_cnt;
   logic                     is_eof;
   logic                     is_eob;

   assign pop_o = beat_avail_i && space_i;

   assign frm          = beat_i[lz_sym_pkg::BW_FRM_LSB  +: 4];
   assign data         = beat_i[lz_sym_pkg::BW_DATA_LSB +: 32];
   assign offset_msb   = beat_i[lz_sym_pkg::BW_OMSB_LSB +: 8];
   assign length       = beat_i[lz_sym_pkg::BW_LEN_LSB  +: 8];
   assign backref      = beat_i[lz_sym_pkg::BW_BACKREF];
   assign backref_lane = beat_i[lz_sym_pkg::BW_LANE_LSB +: 2];

   always_comb begin
      lit_cnt = '0;
      is_eof  = 1'b0;
      is_eob  = 1'b0;
      case (frm)
         lz_sym_pkg::FRM_LIT1, lz_sym_pkg::FRM_LIT2,
         lz_sym_pkg::FRM_LIT3, lz_sym_pkg::FRM_LIT4: lit_cnt = frm[2:0];
         lz_sym_pkg::FRM_EOF:  is_eof  = 1'b1;
         lz_sym_pkg::FRM_EOB:  is_eob  = 1'b1;
         default:              lit_cnt = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < lz_sym_pkg::NUM_LANES; i++) begin
            lit_valid_o[i] <= 1'b0;
            ptr_valid_o[i] <= 1'b0;
         end
         eof_o <= 1'b0;
         eob_o <= 1'b0;
      end else begin
         // Only lanes below the count carry symbols
         for (int i = 0; i < lz_sym_pkg::NUM_LANES; i++) begin
            lit_valid_o[i] <= pop_o && (i < lit_cnt) && !(backref && (backref_lane == i));
            ptr_valid_o[i] <= pop_o && (i < lit_cnt) && backref && (backref_lane == i);
         end
         eof_o <= pop_o && is_eof;
         eob_o <= pop_o && is_eob;
      end
   end

   always_ff @(posedge clk) begin
      if (pop_o) begin
         for (int i = 0; i < lz_sym_pkg::NUM_LANES; i++) begin
            lit_byte_o[i]   <= data[8*i +: 8];
            ptr_offset_o[i] <= {offset_msb, data[8*i +: 8]};
            ptr_length_o[i] <= length;
         end
         eof_code_o <= data;
      end
   end

endmodule

`default_nettype wire

/* logic/lz_sym_pack.sv */
`timescale 1ns/1ns
`default_nettype none

module lz_sym_pack (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     lit_valid_i  [lz_sym_pkg::NUM_LANES],
   input  lz_sym_pkg::lane_byte_t   lit_byte_i   [lz_sym_pkg::NUM_LANES],
   input  logic                     ptr_valid_i  [lz_sym_pkg::NUM_LANES],
   input  lz_sym_pkg::ptr_offset_t  ptr_offset_i [lz_sym_pkg::NUM_LANES],
   input  lz_sym_pkg::ptr_length_t  ptr_length_i [lz_sym_pkg::NUM_LANES],
   input  logic                     eof_i,
   input  logic                     eob_i,
   input  lz_sym_pkg::beat_data_t   eof_code_i,
   lz_sym_wr_if.packer              wr_o
);

   function automatic lz_sym_pkg::sym_word_t make_word(
      input logic                  lit,
      input logic                  ptr,
      input logic                  eof,
      input logic                  eob,
      input lz_sym_pkg::lit_cnt_t  cnt,
      input lz_sym_pkg::sym_data_t data
   );
      lz_sym_pkg::sym_word_t w;
      w = '0;
      w[lz_sym_pkg::SW_LIT]            = lit;
      w[lz_sym_pkg::SW_PTR]            = ptr;
      w[lz_sym_pkg::SW_EOF]            = eof;
      w[lz_sym_pkg::SW_EOB]            = eob;
      w[lz_sym_pkg::SW_CNT_LSB  +: 3]  = cnt;
      w[lz_sym_pkg::SW_DATA_LSB +: 32] = data;
      return w;
   endfunction

   lz_sym_pkg::lane_idx_t  wr_idx;
   lz_sym_pkg::lane_idx_t  lane;
   lz_sym_pkg::sym_word_t  words [3];  // At most head literals, pointer, tail literals
   logic [1:0]             n_words;
   logic                   ptr_seen;
   lz_sym_pkg::lit_cnt_t   cnt_head;
   lz_sym_pkg::lit_cnt_t   cnt_tail;
   lz_sym_pkg::sym_data_t  lit_head;
   lz_sym_pkg::sym_data_t  lit_tail;
   lz_sym_pkg::sym_data_t  ptr_data;

   always_comb begin
      ptr_seen = 1'b0;
      cnt_head = '0;
      cnt_tail = '0;
      lit_head = '0;
      lit_tail = '0;
      ptr_data = '0;
      for (int j = 0; j < lz_sym_pkg::NUM_LANES; j++) begin
         if (ptr_valid_i[j]) begin
            ptr_seen = 1'b1;
            ptr_data = {8'h00, ptr_offset_i[j], ptr_length_i[j]};
         end else if (lit_valid_i[j] && !ptr_seen) begin
            lit_head[8*cnt_head +: 8] = lit_byte_i[j];  // Fill from the low byte
            cnt_head = cnt_head + 1'b1;
         end else if (lit_valid_i[j]) begin
            lit_tail[8*cnt_tail +: 8] = lit_byte_i[j];
            cnt_tail = cnt_tail + 1'b1;
         end
      end
   end

   always_comb begin
      n_words = '0;
      for (int k = 0; k < 3; k++) begin
         words[k] = '0;
      end
      if (cnt_head != '0) begin
         words[n_words] = make_word(1'b1, 1'b0, 1'b0, 1'b0, cnt_head, lit_head);
         n_words = n_words + 1'b1;
      end
      if (ptr_seen) begin
         words[n_words] = make_word(1'b0, 1'b1, 1'b0, 1'b0, '0, ptr_data);
         n_words = n_words + 1'b1;
      end
      if (cnt_tail != '0) begin
         words[n_words] = make_word(1'b1, 1'b0, 1'b0, 1'b0, cnt_tail, lit_tail);
         n_words = n_words + 1'b1;
      end
      if (eof_i) begin
         words[n_words] = make_word(1'b0, 1'b0, 1'b1, 1'b0, '0, eof_code_i);
         n_words = n_words + 1'b1;
      end else if (eob_i) begin
         words[n_words] = make_word(1'b0, 1'b0, 1'b0, 1'b1, '0, '0);
         n_words = n_words + 1'b1;
      end
   end

   // Word k goes to the k-th lane after the write index
   always_comb begin
      lane = wr_idx;
      for (int l = 0; l < lz_sym_pkg::NUM_LANES; l++) begin
         wr_o.wr[l]      = 1'b0;
         wr_o.wr_word[l] = '0;
      end
      for (int k = 0; k < 3; k++) begin
         lane = wr_idx + lz_sym_pkg::lane_idx_t'(k);
         if (k < n_words) begin
            wr_o.wr[lane]      = 1'b1;
            wr_o.wr_word[lane] = words[k];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_idx <= '0;
      end else begin
         wr_idx <= wr_idx + n_words;
      end
   end

endmodule

`default_nettype wire

/* logic/lz_sym_lanes.sv */
`timescale 1ns/1ns
`default_nettype none

module lz_sym_lanes (
   input  logic                   clk,
   input  logic                   rst_n,
   lz_sym_wr_if.lanes             wr_i,
   input  logic                   req_i,
   output lz_sym_pkg::sym_word_t  word_o,
   output logic                   valid_o
);

   logic                   empty   [lz_sym_pkg::NUM_LANES];
   logic                   rd      [lz_sym_pkg::NUM_LANES];
   lz_sym_pkg::sym_word_t  rd_word [lz_sym_pkg::NUM_LANES];
   logic [$clog2(lz_sym_pkg::LANE_FIFO_DEPTH+1)-1:0] free [lz_sym_pkg::NUM_LANES];
   lz_sym_pkg::lane_idx_t  rd_idx;
   logic                   any_avail;

   for (genvar g = 0; g < lz_sym_pkg::NUM_LANES; g++) begin : g_lane
      lz_fifo #(
         .DEPTH (lz_sym_pkg::LANE_FIFO_DEPTH),
         .WIDTH ($bits(lz_sym_pkg::sym_word_t))
      ) u_lane_fifo (
         .clk     (clk),
         .rst_n   (rst_n),
         .wen_i   (wr_i.wr[g]),
         .wdata_i (wr_i.wr_word[g]),
         .ren_i   (rd[g]),
         .rdata_o (rd_word[g]),
         .empty_o (empty[g]),
         .used_o  (),
         .free_o  (free[g])
      );
   end

   always_comb begin
      wr_i.space = 1'b1;
      any_avail  = 1'b0;
      for (int l = 0; l < lz_sym_pkg::NUM_LANES; l++) begin
         if (free[l] <= lz_sym_pkg::LANE_SPACE_MIN) begin
            wr_i.space = 1'b0;  // Covers one beat still in decode
         end
         if (!empty[l]) begin
            any_avail = 1'b1;
         end
         rd[l] = 1'b0;
      end
      if (req_i && any_avail) begin
         rd[rd_idx] = 1'b1;
      end
   end

   assign valid_o = req_i && any_avail;
   assign word_o  = rd_word[rd_idx];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_idx <= '0;
      end else if (valid_o) begin
         rd_idx <= rd_idx + 1'b1;  // Same rotation as the writes
      end
   end

endmodule

`default_nettype wire

/* logic/lz77_sym_if.sv */
`timescale 1ns/1ns
`default_nettype none

module lz77_sym_if (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     valid_i,
   input  lz_sym_pkg::framing_t     framing_i,
   input  lz_sym_pkg::beat_data_t   data_i,
   input  lz_sym_pkg::offset_msb_t  offset_msb_i,
   input  lz_sym_pkg::ptr_length_t  length_i,
   input  logic                     backref_i,
   input  lz_sym_pkg::lane_idx_t    backref_lane_i,
   input  logic                     bypass_i,
   output logic                     ready_o,
   input  logic                     sym_req_i,
   output logic                     sym_valid_o,
   output logic                     sym_lit_o,
   output logic                     sym_ptr_o,
   output logic                     sym_eof_o,
   output logic                     sym_eob_o,
   output lz_sym_pkg::lit_cnt_t     sym_lit_cnt_o,
   output lz_sym_pkg::sym_data_t    sym_data_o
);

   lz_sym_pkg::beat_word_t   beat;
   logic                     beat_avail;
   logic                     pop;
   logic                     lit_valid  [lz_sym_pkg::NUM_LANES];
   lz_sym_pkg::lane_byte_t   lit_byte   [lz_sym_pkg::NUM_LANES];
   logic                     ptr_valid  [lz_sym_pkg::NUM_LANES];
   lz_sym_pkg::ptr_offset_t  ptr_offset [lz_sym_pkg::NUM_LANES];
   lz_sym_pkg::ptr_length_t  ptr_length [lz_sym_pkg::NUM_LANES];
   logic                     eof;
   logic                     eob;
   lz_sym_pkg::beat_data_t   eof_code;
   lz_sym_pkg::sym_word_t    sym_word;

   lz_sym_wr_if sym_wr ();

   lz_beat_queue u_queue (
      .clk, .rst_n, .valid_i, .framing_i, .data_i, .offset_msb_i, .length_i,
      .backref_i, .backref_lane_i, .bypass_i,
      .pop_i        (pop),
      .beat_o       (beat),
      .beat_avail_o (beat_avail),
      .ready_o
   );

   lz_beat_decode u_decode (
      .clk, .rst_n,
      .beat_i       (beat),
      .beat_avail_i (beat_avail),
      .space_i      (sym_wr.space),
      .pop_o        (pop),
      .lit_valid_o  (lit_valid),
      .lit_byte_o   (lit_byte),
      .ptr_valid_o  (ptr_valid),
      .ptr_offset_o (ptr_offset),
      .ptr_length_o (ptr_length),
      .eof_o        (eof),
      .eob_o        (eob),
      .eof_code_o   (eof_code)
   );

   lz_sym_pack u_pack (
      .clk, .rst_n,
      .lit_valid_i  (lit_valid),
      .lit_byte_i   (lit_byte),
      .ptr_valid_i  (ptr_valid),
      .ptr_offset_i (ptr_offset),
      .ptr_length_i (ptr_length),
      .eof_i        (eof),
      .eob_i        (eob),
      .eof_code_i   (eof_code),
      .wr_o         (sym_wr.packer)
   );

   lz_sym_lanes u_lanes (
      .clk, .rst_n,
      .wr_i    (sym_wr.lanes),
      .req_i   (sym_req_i),
      .word_o  (sym_word),
      .valid_o (sym_valid_o)
   );

   assign sym_lit_o     = sym_word[lz_sym_pkg::SW_LIT];
   assign sym_ptr_o     = sym_word[lz_sym_pkg::SW_PTR];
   assign sym_eof_o     = sym_word[lz_sym_pkg::SW_EOF];
   assign sym_eob_o     = sym_word[lz_sym_pkg::SW_EOB];
   assign sym_lit_cnt_o = sym_word[lz_sym_pkg::SW_CNT_LSB +: 3];
   assign sym_data_o    = sym_word[lz_sym_pkg::SW_DATA_LSB +: 32];

endmodule

`default_nettype wire

/* test/tb_lz77_sym_if.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_lz77_sym_if;

   localparam int HALF_PERIOD  = 20;
   localparam int SAMPLE_DELAY = 10;   // Mid-cycle sample point after a falling edge
   localparam int WAIT_LIMIT   = 200;  // Cycles allowed per wait loop

   logic                     clk;
   logic                     rst_n;
   logic                     valid_i;
   lz_sym_pkg::framing_t     framing_i;
   lz_sym_pkg::beat_data_t   data_i;
   lz_sym_pkg::offset_msb_t  offset_msb_i;
   lz_sym_pkg::ptr_length_t  length_i;
   logic                     backref_i;
   lz_sym_pkg::lane_idx_t    backref_lane_i;
   logic                     bypass_i;
   logic                     ready_o;
   logic                     sym_req_i;
   logic                     sym_valid_o;
   logic                     sym_lit_o;
   logic                     sym_ptr_o;
   logic                     sym_eof_o;
   logic                     sym_eob_o;
   lz_sym_pkg::lit_cnt_t     sym_lit_cnt_o;
   lz_sym_pkg::sym_data_t    sym_data_o;

   int          fd;
   int          n;
   int          errors;
   int          checks;
   int          test_errs;
   int          test_checks;
   int          cur_test;
   int          num_tests;
   bit          aborted;
   bit          at_end;
   logic [63:0] kind;
   logic [31:0] f0, f1, f2, f3, f4, f5, f6;

   lz77_sym_if dut0 (
      .clk            (clk),
      .rst_n          (rst_n),
      .valid_i        (valid_i),
      .framing_i      (framing_i),
      .data_i         (data_i),
      .offset_msb_i   (offset_msb_i),
      .length_i       (length_i),
      .backref_i      (backref_i),
      .backref_lane_i (backref_lane_i),
      .bypass_i       (bypass_i),
      .ready_o        (ready_o),
      .sym_req_i      (sym_req_i),
      .sym_valid_o    (sym_valid_o),
      .sym_lit_o      (sym_lit_o),
      .sym_ptr_o      (sym_ptr_o),
      .sym_eof_o      (sym_eof_o),
      .sym_eob_o      (sym_eob_o),
      .sym_lit_cnt_o  (sym_lit_cnt_o),
      .sym_data_o     (sym_data_o)
   );

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      test_checks++;
      if (got !== exp) begin
         $display("ERROR: %s got 0x%08h expected 0x%08h", name, got, exp);
         errors++;
         test_errs++;
      end
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      errors++;
      test_errs++;
      aborted = 1'b1;  // Stops reading further lines
   endtask

   task automatic finish_test();
      if (cur_test != 0) begin
         num_tests++;
         $display("Test %0d done: %0d checks, %0d errors, %s", cur_test, test_checks,
                  test_errs, (test_errs == 0) ? "ok" : "with errors");
      end
      test_checks = 0;
      test_errs   = 0;
   endtask

   task automatic skip_line();
      int c;
      c = $fgetc(fd);
      while (c != 10 && c != -1) begin
         c = $fgetc(fd);
      end
   endtask

   task automatic hold_req(input int cycles);
      sym_req_i = 1'b0;
      repeat (cycles) @(negedge clk);
   endtask

   task automatic drive_beat(input logic [31:0] frm, input logic [31:0] data,
                             input logic [31:0] omsb, input logic [31:0] len,
                             input logic [31:0] br, input logic [31:0] lane,
                             input logic [31:0] byp);
      int waited;
      waited = 0;
      @(negedge clk);
      while (!ready_o && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!ready_o) begin
         abort_run("Timed out waiting for ready_o before sending a beat");
      end else begin
         framing_i      = frm[3:0];
         data_i         = data;
         offset_msb_i   = omsb[7:0];
         length_i       = len[7:0];
         backref_i      = br[0];
         backref_lane_i = lane[1:0];
         bypass_i       = byp[0];
         valid_i        = 1'b1;
         @(negedge clk);
         valid_i = 1'b0;
      end
   endtask

   // Requests one symbol and compares it once sym_valid_o shows up
   task automatic expect_symbol(input logic [31:0] lit, input logic [31:0] ptr,
                                input logic [31:0] eof, input logic [31:0] eob,
                                input logic [31:0] cnt, input logic [31:0] data);
      int waited;
      waited = 0;
      @(negedge clk);
      sym_req_i = 1'b1;
      #SAMPLE_DELAY;
      while (!sym_valid_o && waited < WAIT_LIMIT) begin
         @(negedge clk);
         #SAMPLE_DELAY;
         waited++;
      end
      if (!sym_valid_o) begin
         abort_run("Timed out waiting for sym_valid_o on an expected symbol");
      end else begin
         check_val("sym_lit_o", 32'(sym_lit_o), lit);
         check_val("sym_ptr_o", 32'(sym_ptr_o), ptr);
         check_val("sym_eof_o", 32'(sym_eof_o), eof);
         check_val("sym_eob_o", 32'(sym_eob_o), eob);
         check_val("sym_lit_cnt_o", 32'(sym_lit_cnt_o), cnt);
         check_val("sym_data_o", sym_data_o, data);
      end
      @(negedge clk);
      sym_req_i = 1'b0;  // Word popped on the rising edge in between
   endtask

   task automatic check_idle(input logic [31:0] exp_ready, input logic [31:0] exp_valid);
      @(negedge clk);
      sym_req_i = 1'b1;
      #SAMPLE_DELAY;
      check_val("ready_o", 32'(ready_o), exp_ready);
      check_val("sym_valid_o", 32'(sym_valid_o), exp_valid);
      @(negedge clk);
      sym_req_i = 1'b0;
   endtask

   // Back-to-back four-literal beats with the request low, then drain in order
   task automatic fill_and_drain(input logic [31:0] base, input int limit);
      int sent;
      sent = 0;
      sym_req_i = 1'b0;
      @(negedge clk);
      while (ready_o && sent < limit) begin
         framing_i      = lz_sym_pkg::FRM_LIT4;
         data_i         = base + 32'(sent);
         offset_msb_i   = '0;
         length_i       = '0;
         backref_i      = 1'b0;
         backref_lane_i = '0;
         bypass_i       = 1'b0;
         valid_i        = 1'b1;
         sent++;
         @(negedge clk);
      end
      valid_i = 1'b0;
      if (ready_o) begin
         abort_run("ready_o did not fall while sym_req_i was held low");
      end else begin
         $display("ready_o fell after %0d beats", sent);
         for (int i = 0; i < sent && !aborted; i++) begin
            expect_symbol(1, 0, 0, 0, 4, base + 32'(i));
         end
      end
   endtask

   initial begin
      rst_n          = 1'b0;
      valid_i        = 1'b0;
      framing_i      = '0;
      data_i         = '0;
      offset_msb_i   = '0;
      length_i       = '0;
      backref_i      = 1'b0;
      backref_lane_i = '0;
      bypass_i       = 1'b0;
      sym_req_i      = 1'b0;
      errors         = 0;
      checks         = 0;
      test_errs      = 0;
      test_checks    = 0;
      cur_test       = 0;
      num_tests      = 0;
      aborted        = 1'b0;
      at_end         = 1'b0;

      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      fd = $fopen("test/lz77_sym_golden.txt", "r");
      if (fd == 0) begin
         abort_run("Could not open test/lz77_sym_golden.txt");
      end
      while (!aborted && !at_end) begin
         n = $fscanf(fd, "%s", kind);
         if (n != 1) begin
            at_end = 1'b1;
         end else if (kind == "#") begin
            skip_line();
         end else if (kind == "T") begin
            n = $fscanf(fd, "%d", f0);
            finish_test();
            cur_test = int'(f0);
         end else if (kind == "I") begin
            n = $fscanf(fd, "%d %d", f0, f1);
            check_idle(f0, f1);
         end else if (kind == "H") begin
            n = $fscanf(fd, "%d", f0);
            hold_req(int'(f0));
         end else if (kind == "B") begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6);
            drive_beat(f0, f1, f2, f3, f4, f5, f6);
         end else if (kind == "E") begin
            n = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
            expect_symbol(f0, f1, f2, f3, f4, f5);
         end else if (kind == "F") begin
            n = $fscanf(fd, "%h %d", f0, f1);
            fill_and_drain(f0, int'(f1));
         end else begin
            abort_run("Unknown line kind in the golden file");
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end

      finish_test();
      $display("Summary: %0d tests, %0d checks, %0d errors", num_tests, checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
logic/lz_sym_pkg.sv
logic/lz_sym_wr_if.sv
logic/lz_fifo.sv
logic/lz_beat_queue.sv
logic/lz_beat_decode.sv
logic/lz_sym_pack.sv
logic/lz_sym_lanes.sv
logic/lz77_sym_if.sv
test/tb_lz77_sym_if.sv

/* run.sh */
#!/bin/bash
# Compile with Verilator, run into sim.log, then search the log for the fail message

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_lz77_sym_if \
   -f filelist.f -o sim_tb \
   && ./obj_dir/sim_tb > sim.log 2>&1 \
   || { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -q "Test failed" sim.log \
   && { echo "Simulation reported a failure"; exit 1; } \
   || { echo "Simulation reported no failure"; exit 0; }

/* test/lz77_sym_golden.txt */
# T test_no | I ready valid | H cycles | F data_base max_beats (decimal counts)
# B frm data omsb len backref lane bypass | E lit ptr eof eob cnt data (hex)
T 1
I 1 0
T 2
B 1 a1b2c3d4 00 00 0 0 0
B 2 11223344 00 00 0 0 0
B 3 55667788 00 00 0 0 0
B 4 99aabbcc 00 00 0 0 0
H 4
E 1 0 0 0 1 000000d4
E 1 0 0 0 2 00003344
E 1 0 0 0 3 00667788
E 1 0 0 0 4 99aabbcc
T 3
B 4 deadbeef 12 2a 1 1 0
B 4 cafef00d 03 10 1 0 0
B 4 01020304 80 05 1 3 0
E 1 0 0 0 1 000000ef
E 0 1 0 0 0 0012be2a
E 1 0 0 0 2 0000dead
E 0 1 0 0 0 00030d10
E 1 0 0 0 3 00cafef0
E 1 0 0 0 3 00020304
E 0 1 0 0 0 00800105
T 4
B f 0badc0de 00 00 0 0 0
B 8 12345678 55 66 0 0 0
E 0 0 1 0 0 0badc0de
E 0 0 0 1 0 00000000
T 5
B 4 deadbeef 12 2a 1 1 1
E 1 0 0 0 4 deadbeef
T 6
H 4
F 10000000 120
I 1 0
